/* eth_rx.f */
verilog/eth_rx_pkg.sv
verilog/rmii_rx_front.sv
verilog/dibits_to_bytes.sv
verilog/crc32_dibit_check.sv
verilog/frame_writer.sv
verilog/eth_rx_top.sv
sim/eth_rx_props.sv
sim/eth_rx_tb.sv

/* sim/eth_rx_tb.sv */
/*
 * Testbench for the Ethernet RMII receive path
 * Sends table-driven frames, checks result pulses and buffer contents
 */
`timescale 1ns/10ps

module eth_rx_tb import eth_rx_pkg::*; ();

	localparam int MAX_TESTS = 32;
	localparam int MAX_BYTES = 2048;
	localparam logic [31:0] SEED_BASE = 32'ha773_4e39;

	// Expected outcome per test
	localparam int EXP_NONE = 0;
	localparam int EXP_VALID = 1;
	localparam int EXP_ERR = 2;

	logic       clk;
	logic       rst;
	logic       crs_dv;
	dibit_t     rxd;
	buf_addr_t  rd_addr;
	byte_t      rd_data;
	logic       frame_valid;
	logic       frame_err;
	buf_addr_t  frame_start;
	frame_len_t frame_len;

	// Stimulus table
	int t_len [MAX_TESTS];
	int t_seed_off [MAX_TESTS];
	int t_pre [MAX_TESTS];
	bit t_bad_fcs [MAX_TESTS];
	int t_dribble [MAX_TESTS];
	bit t_noise [MAX_TESTS];
	int t_expect [MAX_TESTS];
	int n_tests;

	byte_t     frame_buf [MAX_BYTES];
	integer    seed;
	buf_addr_t model_ptr;
	int        errors;
	int        test_errors;
	int        failed_tests;
	int        prop_fails;
	int        cycles = 0;
	int        cycle_limit = 0;

	eth_rx_top DUT (
		.clk         (clk),
		.rst         (rst),
		.crs_dv      (crs_dv),
		.rxd         (rxd),
		.rd_addr     (rd_addr),
		.rd_data     (rd_data),
		.frame_valid (frame_valid),
		.frame_err   (frame_err),
		.frame_start (frame_start),
		.frame_len   (frame_len)
	);

	initial clk = 1'b0;
	always #20 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("timeout after %0d cycles, the tests did not finish", cycles);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	task automatic add_test(input int len, input int seed_off, input int pre,
			input bit bad_fcs, input int dribble, input bit noise, input int expect_code);
		t_len[n_tests] = len;
		t_seed_off[n_tests] = seed_off;
		t_pre[n_tests] = pre;
		t_bad_fcs[n_tests] = bad_fcs;
		t_dribble[n_tests] = dribble;
		t_noise[n_tests] = noise;
		t_expect[n_tests] = expect_code;
		n_tests++;
	endtask

	task automatic load_table();
		n_tests = 0;
		// len, seed offset, preamble, bad FCS, dribble, noise, expected
		add_test(1, 0, 7, 0, 0, 0, EXP_VALID);
		add_test(46, 1, 7, 0, 0, 0, EXP_VALID);
		add_test(60, 2, 3, 0, 0, 0, EXP_VALID);
		add_test(20, 3, 7, 1, 0, 0, EXP_ERR);
		add_test(20, 4, 7, 0, 0, 0, EXP_VALID);
		add_test(30, 5, 7, 0, 1, 0, EXP_ERR);
		add_test(30, 6, 7, 0, 2, 0, EXP_ERR);
		add_test(30, 7, 7, 0, 3, 0, EXP_ERR);
		add_test(12, 8, 0, 0, 0, 1, EXP_NONE);
		add_test(12, 9, 1, 0, 0, 0, EXP_NONE);
		add_test(8, 10, 2, 0, 0, 0, EXP_VALID);
		// Large frames to run the write pointer past the top of the buffer
		add_test(700, 11, 7, 0, 0, 0, EXP_VALID);
		add_test(900, 12, 7, 0, 0, 0, EXP_VALID);
		add_test(600, 13, 7, 0, 0, 0, EXP_VALID);
		add_test(40, 14, 7, 0, 0, 0, EXP_VALID);
		add_test(33, 15, 5, 1, 0, 0, EXP_ERR);
		add_test(5, 16, 7, 0, 0, 0, EXP_VALID);
	endtask

	function automatic int limit_from_table();
		int sum;
		sum = 0;
		for (int i = 0; i < n_tests; i++)
			sum += 4 * (t_len[i] + 4) + t_pre[i] + 40;
		return 2 * sum;
	endfunction

	// Ethernet FCS over the first n bytes, bitwise and LSB first
	function automatic crc_t fcs_of(input int n);
		crc_t c;
		c = CRC_INIT;
		for (int i = 0; i < n; i++) begin
			c = c ^ {24'd0, frame_buf[i]};
			for (int k = 0; k < 8; k++)
				c = c[0] ? ((c >> 1) ^ CRC_POLY) : (c >> 1);
		end
		return ~c;
	endfunction

	task automatic send_dibit(input dibit_t d);
		@(posedge clk);
		crs_dv <= 1'b1;
		rxd <= d;
	endtask

	task automatic send_byte(input byte_t b);
		for (int k = 0; k < 4; k++)
			send_dibit(b[2*k +: 2]);
	endtask

	task automatic check_readback(input int idx, input buf_addr_t base, input int n);
		buf_addr_t a;
		for (int i = 0; i < n; i++) begin
			a = buf_addr_t'((int'(base) + i) % BUF_SIZE);
			@(posedge clk);
			rd_addr <= a;
			@(posedge clk);
			@(negedge clk);
			assert (rd_data === frame_buf[i]) else begin
				$display("ERROR: test %0d rd_data at %h got %h expected %h",
					idx, a, rd_data, frame_buf[i]);
				test_errors++;
			end
		end
	endtask

	task automatic run_test(input int idx);
		int         n;
		int         pulses;
		int         first_at;
		logic       got_valid;
		buf_addr_t  got_start;
		frame_len_t got_len;
		crc_t       fcs;
		test_errors = 0;
		pulses = 0;
		first_at = -1;
		got_valid = 1'b0;
		got_start = '0;
		got_len = '0;

		seed = SEED_BASE + t_seed_off[idx];
		for (int i = 0; i < t_len[idx]; i++)
			frame_buf[i] = byte_t'($random(seed));
		fcs = fcs_of(t_len[idx]);
		n = t_len[idx] + 4;
		for (int k = 0; k < 4; k++)
			frame_buf[t_len[idx] + k] = fcs[8*k +: 8];
		if (t_bad_fcs[idx])
			frame_buf[n - 1] ^= byte_t'(1 << (t_seed_off[idx] % 8));

		if (t_noise[idx]) begin
			// Opens with a symbol that is not preamble
			send_dibit(2'b10);
			for (int i = 1; i < 4 * n; i++)
				send_dibit(dibit_t'($random(seed)));
		end else begin
			repeat (t_pre[idx]) send_dibit(2'b01);
			send_dibit(2'b11);
			for (int i = 0; i < n; i++)
				send_byte(frame_buf[i]);
			repeat (t_dribble[idx]) send_dibit(dibit_t'($random(seed)));
		end
		@(posedge clk);
		crs_dv <= 1'b0;
		rxd <= 2'b00;

		// Idle gap, watching for the result pulse
		for (int c = 0; c < 12; c++) begin
			@(negedge clk);
			if (frame_valid || frame_err) begin
				pulses++;
				if (first_at < 0) begin
					first_at = c;
					got_valid = frame_valid;
					got_start = frame_start;
					got_len = frame_len;
				end
			end
		end

		if (t_expect[idx] == EXP_NONE) begin
			assert (pulses == 0) else begin
				$display("test %0d: a result pulse came for carrier that should be ignored", idx);
				test_errors++;
			end
		end else begin
			assert (first_at >= 0 && first_at < 8) else begin
				$display("test %0d: no frame_valid or frame_err within 8 cycles of carrier drop",
					idx);
				test_errors++;
			end
			assert (pulses <= 1) else begin
				$display("test %0d: more than one result pulse for one frame", idx);
				test_errors++;
			end
			assert (got_valid == (t_expect[idx] == EXP_VALID)) else begin
				$display("ERROR: test %0d frame_valid got %h expected %h",
					idx, got_valid, t_expect[idx] == EXP_VALID);
				test_errors++;
			end
			if (got_valid && t_expect[idx] == EXP_VALID) begin
				assert (got_start == model_ptr) else begin
					$display("ERROR: test %0d frame_start got %h expected %h",
						idx, got_start, model_ptr);
					test_errors++;
				end
				assert (got_len == frame_len_t'(n)) else begin
					$display("ERROR: test %0d frame_len got %h expected %h", idx, got_len, n);
					test_errors++;
				end
				check_readback(idx, model_ptr, n);
				model_ptr = buf_addr_t'((int'(model_ptr) + n) % BUF_SIZE);
			end
		end

		$display("test %0d: %0d payload bytes, %s", idx, t_len[idx],
			test_errors == 0 ? "ok" : "failed");
		errors += test_errors;
		if (test_errors != 0)
			failed_tests++;
	endtask

	initial begin
		rst = 1'b1;
		crs_dv = 1'b0;
		rxd = 2'b00;
		rd_addr = '0;
		errors = 0;
		failed_tests = 0;
		model_ptr = '0;
		load_table();
		cycle_limit = limit_from_table();

		repeat (8) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		assert (!frame_valid && !frame_err) else begin
			$display("ERROR: after reset frame_valid %h frame_err %h expected 0",
				frame_valid, frame_err);
			errors++;
		end

		for (int i = 0; i < n_tests; i++)
			run_test(i);

		prop_fails = DUT.writer.writer_props.violations + DUT.front.front_props.violations;
		assert (prop_fails == 0) else begin
			$display("bound property checks failed %0d times", prop_fails);
			errors += prop_fails;
		end

		$display("%0d tests, %0d passed, %0d failed, %0d errors",
			n_tests, n_tests - failed_tests, failed_tests, errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

/* sim/eth_rx_props.sv */
/*
 * Bound checks on the receive front end and frame writer strobes
 */
`timescale 1ns/10ps

module eth_rx_props (
	input logic clk,
	input logic rst,
	input logic crs_dv,
	input logic dibit_valid,
	input logic bytes_done,
	input logic frame_valid,
	input logic frame_err
);

	// Failure count for the end-of-run summary
	int violations = 0;

	// A frame either commits or is dropped, never both
	result_exclusive: assert property (@(posedge clk) disable iff (rst)
		!(frame_valid && frame_err))
		else begin
			$error("frame_valid and frame_err high in the same cycle");
			violations++;
		end

	// Result follows the completion strobe by one cycle
	result_after_done: assert property (@(posedge clk) disable iff (rst)
		(frame_valid || frame_err) |-> $past(bytes_done))
		else begin
			$error("result pulse without bytes_done one cycle earlier");
			violations++;
		end

	// Two low carrier samples flush the input pipeline
	no_dibit_after_drop: assert property (@(posedge clk) disable iff (rst)
		!crs_dv ##1 !crs_dv |=> ##1 !dibit_valid)
		else begin
			$error("dibit_valid after carrier was low for two samples");
			violations++;
		end

endmodule

// Writer side, front-end inputs tied off
bind frame_writer eth_rx_props writer_props (
	.clk         (clk),
	.rst         (rst),
	.crs_dv      (1'b1),
	.dibit_valid (1'b0),
	.bytes_done  (bytes_done),
	.frame_valid (frame_valid),
	.frame_err   (frame_err)
);

// Front-end side, writer inputs tied off
bind rmii_rx_front eth_rx_props front_props (
	.clk         (clk),
	.rst         (rst),
	.crs_dv      (crs_dv),
	.dibit_valid (dibit_valid),
	.bytes_done  (1'b0),
	.frame_valid (1'b0),
	.frame_err   (1'b0)
);

/* verilog/eth_rx_top.sv */
/*
 * Ethernet RMII receive path
 * Front end, byte assembler, CRC-32 checker and packet buffer writer
 */
`timescale 1ns/10ps

module eth_rx_top import eth_rx_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       crs_dv,
	input  dibit_t     rxd,
	input  buf_addr_t  rd_addr,
	output byte_t      rd_data,
	output logic       frame_valid,
	output logic       frame_err,
	output buf_addr_t  frame_start,
	output frame_len_t frame_len
);

	logic   dibit_valid;
	dibit_t dibit;
	logic   frame_end;
	logic   byte_valid;
	byte_t  byte_data;
	logic   bytes_done;
	logic   aligned;
	logic   crc_done;
	logic   crc_ok;
	logic   frame_done;

	rmii_rx_front front (
		.clk         (clk),
		.rst         (rst),
		.crs_dv      (crs_dv),
		.rxd         (rxd),
		.dibit_valid (dibit_valid),
		.dibit       (dibit),
		.frame_end   (frame_end)
	);

	dibits_to_bytes dtb (
		.clk         (clk),
		.rst         (rst),
		.dibit_valid (dibit_valid),
		.dibit       (dibit),
		.frame_end   (frame_end),
		.byte_valid  (byte_valid),
		.byte_data   (byte_data),
		.bytes_done  (bytes_done),
		.aligned     (aligned)
	);

	crc32_dibit_check crc (
		.clk         (clk),
		.rst         (rst),
		.dibit_valid (dibit_valid),
		.dibit       (dibit),
		.frame_end   (frame_end),
		.crc_done    (crc_done),
		.crc_ok      (crc_ok)
	);

	// Both checks finish in the same cycle
	assign frame_done = bytes_done && crc_done;

	frame_writer writer (
		.clk         (clk),
		.rst         (rst),
		.byte_valid  (byte_valid),
		.byte_data   (byte_data),
		.bytes_done  (frame_done),
		.aligned     (aligned),
		.crc_ok      (crc_ok),
		.frame_valid (frame_valid),
		.frame_err   (frame_err),
		.frame_start (frame_start),
		.frame_len   (frame_len),
		.rd_addr     (rd_addr),
		.rd_data     (rd_data)
	);

endmodule

/* verilog/frame_writer.sv */
/*
 * Packet buffer frame writer
 * Writes bytes into a ring buffer and commits or rolls back each frame,
 * with a synchronous read port for the consumer
 */
`timescale 1ns/10ps

module frame_writer import eth_rx_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       byte_valid,
	input  byte_t      byte_data,
	input  logic       bytes_done,
	input  logic       aligned,
	input  logic       crc_ok,
	output logic       frame_valid,
	output logic       frame_err,
	output buf_addr_t  frame_start,
	output frame_len_t frame_len,
	input  buf_addr_t  rd_addr,
	output byte_t      rd_data
);

	byte_t mem [BUF_SIZE];

	buf_addr_t  wr_ptr;
	buf_addr_t  start_addr;
	frame_len_t len_cnt;
	logic       good;

	// Frame is kept only if it is whole bytes, has a good FCS and is not empty
	assign good = aligned && crc_ok && (len_cnt != '0);

	always_ff @(posedge clk) begin
		if (byte_valid)
			mem[wr_ptr] <= byte_data;
	end

	always_ff @(posedge clk) begin
		rd_data <= mem[rd_addr];
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			start_addr <= '0;
			len_cnt <= '0;
			frame_valid <= 1'b0;
			frame_err <= 1'b0;
		end else begin
			frame_valid <= 1'b0;
			frame_err <= 1'b0;
			if (bytes_done) begin
				len_cnt <= '0;
				if (good) begin
					frame_valid <= 1'b1;
					start_addr <= wr_ptr;
				end else begin
					// Drop the frame and reuse its space
					frame_err <= 1'b1;
					wr_ptr <= start_addr;
				end
			end else if (byte_valid) begin
				// Pointer wraps at the end of the buffer
				wr_ptr <= wr_ptr + 1'b1;
				len_cnt <= len_cnt + 1'b1;
			end
		end
	end

	// Qualified by frame_valid
	always_ff @(posedge clk) begin
		if (bytes_done) begin
			frame_start <= start_addr;
			frame_len <= len_cnt;
		end
	end

endmodule

/* verilog/crc32_dibit_check.sv */
/*
 * Ethernet CRC-32 checker, two bits per cycle
 * Runs over the payload and FCS, then tests for the fixed residue
 */
`timescale 1ns/10ps

module crc32_dibit_check import eth_rx_pkg::*; (
	input  logic   clk,
	input  logic   rst,
	input  logic   dibit_valid,
	input  dibit_t dibit,
	input  logic   frame_end,
	output logic   crc_done,
	output logic   crc_ok
);

	crc_t crc;
	crc_t crc_next;

	// One step of the reflected LFSR
	function automatic crc_t crc_step(input crc_t c, input logic b);
		logic fb;
		fb = c[0] ^ b;
		crc_step = (c >> 1) ^ (fb ? CRC_POLY : 32'd0);
	endfunction

	// Bit 0 of the dibit is first on the wire
	always_comb begin
		crc_next = crc_step(crc_step(crc, dibit[0]), dibit[1]);
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			crc <= CRC_INIT;
			crc_done <= 1'b0;
			crc_ok <= 1'b0;
		end else begin
			crc_done <= 1'b0;
			if (frame_end) begin
				crc_done <= 1'b1;
				crc_ok <= (crc == CRC_RESIDUE);
				crc <= CRC_INIT;
			end else if (dibit_valid) begin
				crc <= crc_next;
			end
		end
	end

endmodule

/* verilog/dibits_to_bytes.sv */
/*
 * Dibit to byte assembler
 * Packs four dibits per byte, first dibit in the low bits,
 * and reports whether the frame ended on a byte boundary
 */
`timescale 1ns/10ps

module dibits_to_bytes import eth_rx_pkg::*; (
	input  logic   clk,
	input  logic   rst,
	input  logic   dibit_valid,
	input  dibit_t dibit,
	input  logic   frame_end,
	output logic   byte_valid,
	output byte_t  byte_data,
	output logic   bytes_done,
	output logic   aligned
);

	logic [1:0] phase;
	byte_t      shift;

	// New dibits enter at the top and move down
	always_ff @(posedge clk) begin
		if (dibit_valid)
			shift <= {dibit, shift[7:2]};
	end

	// Complete byte sits in the shift register while byte_valid is high
	assign byte_data = shift;

	always_ff @(posedge clk) begin
		if (rst) begin
			phase <= 2'd0;
			byte_valid <= 1'b0;
			bytes_done <= 1'b0;
			aligned <= 1'b0;
		end else begin
			byte_valid <= 1'b0;
			bytes_done <= 1'b0;
			if (frame_end) begin
				bytes_done <= 1'b1;
				aligned <= (phase == 2'd0);
				phase <= 2'd0;
			end else if (dibit_valid) begin
				phase <= phase + 2'd1;
				if (phase == 2'd3)
					byte_valid <= 1'b1;
			end
		end
	end

endmodule

/* verilog/rmii_rx_front.sv */
/*
 * RMII receive front end
 * Samples crs_dv and rxd, strips preamble and delimiter,
 * and emits payload dibit strobes with an end-of-frame pulse
 */
`timescale 1ns/10ps

module rmii_rx_front import eth_rx_pkg::*; (
	input  logic   clk,
	input  logic   rst,
	input  logic   crs_dv,
	input  dibit_t rxd,
	output logic   dibit_valid,
	output dibit_t dibit,
	output logic   frame_end
);

	// Input sample and one stage of delay
	logic      crs_s;
	logic      crs_d;
	dibit_t    rxd_s;
	dibit_t    rxd_d;

	rx_state_t state;
	logic [1:0] pre_cnt;

	always_ff @(posedge clk) begin
		if (rst) begin
			crs_s <= 1'b0;
			crs_d <= 1'b0;
		end else begin
			crs_s <= crs_dv;
			crs_d <= crs_s;
		end
		rxd_s <= rxd;
		rxd_d <= rxd_s;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= rx_idle;
			pre_cnt <= 2'd0;
			dibit_valid <= 1'b0;
			frame_end <= 1'b0;
		end else begin
			dibit_valid <= 1'b0;
			frame_end <= 1'b0;
			case (state)
				rx_idle: begin
					// Carrier must open with a preamble symbol
					if (crs_d) begin
						if (rxd_d == SYM_PREAMBLE) begin
							state <= rx_preamble;
							pre_cnt <= 2'd1;
						end else begin
							state <= rx_wait_idle;
						end
					end
				end
				rx_preamble: begin
					if (!crs_d) begin
						state <= rx_idle;
					end else if (rxd_d == SYM_PREAMBLE) begin
						// Saturate, only the minimum matters
						if (pre_cnt != 2'd3)
							pre_cnt <= pre_cnt + 2'd1;
					end else if (rxd_d == SYM_SFD && pre_cnt >= PREAMBLE_MIN) begin
						state <= rx_payload;
					end else begin
						state <= rx_wait_idle;
					end
				end
				rx_payload: begin
					if (crs_d) begin
						dibit_valid <= 1'b1;
					end else begin
						frame_end <= 1'b1;
						state <= rx_idle;
					end
				end
				rx_wait_idle: begin
					// Ignore the rest of a bad carrier burst
					if (!crs_d)
						state <= rx_idle;
				end
				default: state <= rx_idle;
			endcase
		end
	end

	// Qualified by dibit_valid
	always_ff @(posedge clk) begin
		dibit <= rxd_d;
	end

endmodule

/* verilog/eth_rx_pkg.sv */
/*
 * Ethernet receive path shared definitions
 * Buffer geometry, data typedefs, CRC-32 constants and front-end states
 */
package eth_rx_pkg;

	// Packet buffer geometry
	localparam int BUF_SIZE = 2048;
	localparam int BUF_ADDR_W = $clog2(BUF_SIZE);

	// Data and address vectors
	typedef logic [7:0] byte_t;
	typedef logic [1:0] dibit_t;
	typedef logic [BUF_ADDR_W-1:0] buf_addr_t;
	typedef logic [BUF_ADDR_W-1:0] frame_len_t;
	typedef logic [31:0] crc_t;

	// RMII preamble symbols, least significant bit first on the wire
	localparam dibit_t SYM_PREAMBLE = 2'b01;
	localparam dibit_t SYM_SFD = 2'b11;

	// Shortest preamble accepted before the delimiter
	localparam int PREAMBLE_MIN = 2;

	// Ethernet CRC-32, reflected form
	localparam crc_t CRC_POLY = 32'hEDB8_8320;
	localparam crc_t CRC_INIT = 32'hFFFF_FFFF;
	// Register contents after a good frame and its FCS
	localparam crc_t CRC_RESIDUE = 32'hDEBB_20E3;

	// Receive front-end FSM
	typedef enum logic [1:0] {
		rx_idle,
		rx_preamble,
		rx_payload,
		rx_wait_idle
	} rx_state_t;

endpackage
